// File: tb/decode_vectors.txt
// ctrl fetch_pc rdata_lo rdata_hi pred_baddr, then slot0 and slot1 as pc flags imm waddr
// ctrl bits ready pb0 pb1 trap mret miss hset hrel; flags v exc unit alu(2) fp; FF ends
// Integer decode, both slots
80 00001000 002081B3 FFD00293 00002000 00001000 101000 00000000 03 00001004 101000 FFFFFFFD 05
C0 00001008 123453B7 010000EF 00001100 00001008 1010A0 12345000 07 0000100C 103000 00000010 01
A0 00001010 FE208CE3 00812303 00001008 00001010 1020C0 FFFFFFF8 19 00001014 104000 00000008 06
// Store in slot 0, FP ops through the override
80 00001018 00512623 00412087 00002000 00001018 105000 0000000C 0C 0000101C 108000 00000004 01
80 00001020 00208253 00312827 00002000 00001020 107001 00000000 04 00001024 109000 00000010 10
80 00001028 00412087 1020F2D3 00002000 00001028 108000 00000004 01 0000102C 107003 00000000 05
// Illegal words, then fetch_ready low
80 00001030 FFFFFFFF 002081B3 00002000 00001030 110000 00000000 1F 00001034 101000 00000000 03
80 00001038 FFD00293 00000000 00002000 00001038 101000 FFFFFFFD 05 0000103C 110000 00000000 00
00 00001040 002081B3 FFD00293 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
// Trap, mret and predictor miss
90 00001040 002081B3 FFD00293 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
80 00001040 002081B3 FFD00293 00002000 00001040 101000 00000000 03 00001044 101000 FFFFFFFD 05
88 00001048 123453B7 010000EF 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
84 00001050 FE208CE3 00812303 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
80 00001050 FE208CE3 00812303 00002000 00001050 1020C0 FFFFFFF8 19 00001054 104000 00000008 06
// Halt set, held, released
82 00001058 002081B3 FFD00293 00002000 00001058 101000 00000000 03 0000105C 101000 FFFFFFFD 05
80 00001060 123453B7 010000EF 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
80 00001068 123453B7 010000EF 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
81 00001070 123453B7 010000EF 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
80 00001078 123453B7 010000EF 00002000 00001078 1010A0 12345000 07 0000107C 103000 00000010 01
// Fence in slot 0 drops the next entry
80 00001080 0FF0000F 002081B3 00002000 00001080 106000 00000000 00 00001084 101000 00000000 03
80 00001088 FFD00293 123453B7 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
80 00001090 FFD00293 123453B7 00002000 00001090 101000 FFFFFFFD 05 00001094 1010A0 12345000 07
00 00001098 00000000 00000000 00002000 FFFFFFFF 000000 00000000 00 FFFFFFFF 000000 00000000 00
// End marker
FF

// File: decode.f
logic/decode_pkg.sv
logic/decode_result_if.sv
logic/int_decoder.sv
logic/fp_decoder.sv
logic/decode_ctrl.sv
logic/decode_stage.sv
logic/decode_top.sv
tb/decode_tb.sv

// File: run_decode.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module decode_tb -f decode.f -o decode_sim &&
./obj_dir/decode_sim | tee /dev/stderr | grep -qF 'All tests passed!' &&
echo 'Simulation PASS' || { echo 'Simulation FAIL'; exit 1; }

// File: tb/decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_tb import decode_pkg::*; ();

  localparam int vec_words   = 13; // Hex words per vector line
  localparam int max_vectors = 64;

  logic        clock;
  logic        reset;
  logic        fetch_ready;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_rdata;
  logic        pred_branch0;
  logic        pred_branch1;
  logic [31:0] pred_baddr;
  logic        trap;
  logic        mret;
  logic        pred_miss;
  logic        halt_set;
  logic        halt_release;
  slot_t       slot0;
  slot_t       slot1;

  logic [31:0] words [0:vec_words*max_vectors-1];
  int          n_vectors;
  int          errors;
  logic        loaded;

  decode_top u_dut (
    .clock        (clock),
    .reset        (reset),
    .fetch_ready  (fetch_ready),
    .fetch_pc     (fetch_pc),
    .fetch_rdata  (fetch_rdata),
    .pred_branch0 (pred_branch0),
    .pred_branch1 (pred_branch1),
    .pred_baddr   (pred_baddr),
    .trap         (trap),
    .mret         (mret),
    .pred_miss    (pred_miss),
    .halt_set     (halt_set),
    .halt_release (halt_release),
    .slot0        (slot0),
    .slot1        (slot1)
  );

  always #50 clock = ~clock;

  task automatic report_mismatch(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors = errors + 1;
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, field, expected, actual);
  endtask

  // Flags hold valid, exception, unit, alu_op and fp_op as hex digits
  task automatic check_slot(input string name, input slot_t act, input logic [31:0] exp_pc,
                            input logic [23:0] exp_flags, input logic [31:0] exp_imm,
                            input logic [4:0] exp_waddr);
    if (act.pc !== exp_pc) begin
      report_mismatch({name, ".pc"}, exp_pc, act.pc);
    end
    if (act.valid !== exp_flags[20]) begin
      report_mismatch({name, ".valid"}, {31'd0, exp_flags[20]}, {31'd0, act.valid});
    end
    if (act.exception !== exp_flags[16]) begin
      report_mismatch({name, ".exception"}, {31'd0, exp_flags[16]}, {31'd0, act.exception});
    end
    if (act.unit !== exp_flags[15:12]) begin
      report_mismatch({name, ".unit"}, {28'd0, exp_flags[15:12]}, {28'd0, act.unit});
    end
    if (act.alu_op !== exp_flags[8:4]) begin
      report_mismatch({name, ".alu_op"}, {27'd0, exp_flags[8:4]}, {27'd0, act.alu_op});
    end
    if (act.fp_op !== exp_flags[2:0]) begin
      report_mismatch({name, ".fp_op"}, {29'd0, exp_flags[2:0]}, {29'd0, act.fp_op});
    end
    if (act.imm !== exp_imm) begin
      report_mismatch({name, ".imm"}, exp_imm, act.imm);
    end
    if (act.waddr !== exp_waddr) begin
      report_mismatch({name, ".waddr"}, {27'd0, exp_waddr}, {27'd0, act.waddr});
    end
  endtask

  task automatic apply_vector(input int v);
    int b;
    b = v * vec_words;
    fetch_ready  = words[b][7];
    pred_branch0 = words[b][6];
    pred_branch1 = words[b][5];
    trap         = words[b][4];
    mret         = words[b][3];
    pred_miss    = words[b][2];
    halt_set     = words[b][1];
    halt_release = words[b][0];
    fetch_pc     = words[b + 1];
    fetch_rdata  = {words[b + 3], words[b + 2]};
    pred_baddr   = words[b + 4];
  endtask

  task automatic check_vector(input int v);
    int b;
    b = v * vec_words;
    check_slot("slot0", slot0, words[b + 5], words[b + 6][23:0], words[b + 7],
               words[b + 8][4:0]);
    check_slot("slot1", slot1, words[b + 9], words[b + 10][23:0], words[b + 11],
               words[b + 12][4:0]);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b0;
    fetch_ready  = 1'b0;
    fetch_pc     = 32'd0;
    fetch_rdata  = 64'd0;
    pred_branch0 = 1'b0;
    pred_branch1 = 1'b0;
    pred_baddr   = 32'd0;
    trap         = 1'b0;
    mret         = 1'b0;
    pred_miss    = 1'b0;
    halt_set     = 1'b0;
    halt_release = 1'b0;
    errors       = 0;
    n_vectors    = 0;
    loaded       = 1'b0;

    $readmemh("tb/decode_vectors.txt", words);
    while (n_vectors < max_vectors && words[n_vectors * vec_words] !== 32'hFF) begin
      n_vectors = n_vectors + 1;
    end
    if (n_vectors == 0 || n_vectors == max_vectors) begin
      $display("Vector file is missing, empty or has no end marker");
      errors    = errors + 1;
      n_vectors = 0;
    end
    loaded = 1'b1;

    repeat (8) @(negedge clock);
    check_slot("slot0", slot0, 32'hFFFF_FFFF, 24'h0, 32'd0, 5'd0); // Empty out of reset
    check_slot("slot1", slot1, 32'hFFFF_FFFF, 24'h0, 32'd0, 5'd0);
    reset = 1'b1;

    for (int i = 0; i < n_vectors; i++) begin
      apply_vector(i);
      @(negedge clock);
      check_vector(i); // Output after the edge just passed
    end

    $display("%0d vectors checked, %0d errors", n_vectors, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (loaded);
    #((n_vectors + 20) * 100);
    $display("Timeout: run did not finish within %0d ns, %0d errors so far",
             (n_vectors + 20) * 100, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top import decode_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_ready,
  input  logic [31:0] fetch_pc,
  input  logic [63:0] fetch_rdata,
  input  logic        pred_branch0,
  input  logic        pred_branch1,
  input  logic [31:0] pred_baddr,
  input  logic        trap,
  input  logic        mret,
  input  logic        pred_miss,
  input  logic        halt_set,
  input  logic        halt_release,
  output slot_t       slot0,
  output slot_t       slot1
);

  logic squash;
  logic fence_out;

  decode_result_if int0 ();
  decode_result_if int1 ();
  decode_result_if fp0 ();
  decode_result_if fp1 ();

  int_decoder u_int_dec0 (.dec(int0.decoder));
  int_decoder u_int_dec1 (.dec(int1.decoder));
  fp_decoder  u_fp_dec0  (.dec(fp0.decoder));
  fp_decoder  u_fp_dec1  (.dec(fp1.decoder));

  decode_stage u_stage (
    .clock        (clock),
    .reset        (reset),
    .fetch_ready  (fetch_ready),
    .fetch_pc     (fetch_pc),
    .fetch_rdata  (fetch_rdata),
    .pred_branch0 (pred_branch0),
    .pred_branch1 (pred_branch1),
    .pred_baddr   (pred_baddr),
    .squash       (squash),
    .int0         (int0.stage),
    .int1         (int1.stage),
    .fp0          (fp0.stage),
    .fp1          (fp1.stage),
    .slot0        (slot0),
    .slot1        (slot1),
    .fence_out    (fence_out)
  );

  decode_ctrl u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .halt_set     (halt_set),
    .halt_release (halt_release),
    .trap         (trap),
    .mret         (mret),
    .pred_miss    (pred_miss),
    .fence_out    (fence_out),
    .squash       (squash)
  );

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            fetch_ready,
  input  logic [31:0]     fetch_pc,
  input  logic [63:0]     fetch_rdata,
  input  logic            pred_branch0,
  input  logic            pred_branch1,
  input  logic [31:0]     pred_baddr,
  input  logic            squash,
  decode_result_if.stage  int0,
  decode_result_if.stage  int1,
  decode_result_if.stage  fp0,
  decode_result_if.stage  fp1,
  output slot_t           slot0,
  output slot_t           slot1,
  output logic            fence_out
);

  logic [31:0] instr0;
  logic [31:0] instr1;
  logic [31:0] pc0;
  logic [31:0] pc1;
  slot_t       next0;
  slot_t       next1;

  function automatic slot_t base_slot(
    input logic [31:0] pc,
    input logic [31:0] instr,
    input logic        taken,
    input logic [31:0] taddr
  );
    slot_t s;
    s = empty_slot;
    s.pc         = pc;
    s.npc        = pc + 32'd4;
    s.instr      = instr;
    s.waddr      = instr[11:7];
    s.raddr1     = instr[19:15];
    s.raddr2     = instr[24:20];
    s.pred_taken = taken;
    s.pred_addr  = taddr;
    return s;
  endfunction

  function automatic slot_t take_result(
    input slot_t       s,
    input logic        valid,
    input unit_t       unit,
    input alu_op_t     alu_op,
    input fp_op_t      fp_op,
    input logic [31:0] imm,
    input logic        wren,
    input logic        rden1,
    input logic        rden2,
    input logic        fwren,
    input logic        frden1,
    input logic        frden2,
    input logic        fence
  );
    slot_t r;
    r = s;
    r.valid  = valid;
    r.unit   = unit;
    r.alu_op = alu_op;
    r.fp_op  = fp_op;
    r.imm    = imm;
    r.wren   = wren;
    r.rden1  = rden1;
    r.rden2  = rden2;
    r.fwren  = fwren;
    r.frden1 = frden1;
    r.frden2 = frden2;
    r.fence  = fence;
    return r;
  endfunction

  assign instr0 = fetch_ready ? fetch_rdata[31:0] : 32'd0;
  assign instr1 = fetch_ready ? fetch_rdata[63:32] : 32'd0;
  assign pc0    = fetch_ready ? fetch_pc : pc_none;
  assign pc1    = fetch_ready ? (fetch_pc + 32'd4) : pc_none;

  assign int0.instr = instr0;
  assign fp0.instr  = instr0;
  assign int1.instr = instr1;
  assign fp1.instr  = instr1;

  always_comb begin
    next0 = base_slot(pc0, instr0, pred_branch0, pred_baddr);
    next1 = base_slot(pc1, instr1, pred_branch1, pred_baddr);
    next0 = take_result(next0, int0.valid, int0.unit, int0.alu_op, int0.fp_op, int0.imm,
                        int0.wren, int0.rden1, int0.rden2, int0.fwren, int0.frden1,
                        int0.frden2, int0.fence);
    next1 = take_result(next1, int1.valid, int1.unit, int1.alu_op, int1.fp_op, int1.imm,
                        int1.wren, int1.rden1, int1.rden2, int1.fwren, int1.frden1,
                        int1.frden2, int1.fence);
    if (fp0.valid) begin // FP result wins
      next0 = take_result(next0, fp0.valid, fp0.unit, fp0.alu_op, fp0.fp_op, fp0.imm,
                          fp0.wren, fp0.rden1, fp0.rden2, fp0.fwren, fp0.frden1,
                          fp0.frden2, fp0.fence);
    end
    if (fp1.valid) begin
      next1 = take_result(next1, fp1.valid, fp1.unit, fp1.alu_op, fp1.fp_op, fp1.imm,
                          fp1.wren, fp1.rden1, fp1.rden2, fp1.fwren, fp1.frden1,
                          fp1.frden2, fp1.fence);
    end
    if (fetch_ready && !next0.valid) begin
      next0.valid     = 1'b1;
      next0.exception = 1'b1; // Illegal instruction
    end
    if (fetch_ready && !next1.valid) begin
      next1.valid     = 1'b1;
      next1.exception = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      slot0 <= empty_slot;
      slot1 <= empty_slot;
    end else if (squash) begin
      slot0 <= empty_slot;
      slot1 <= empty_slot;
    end else begin
      slot0 <= next0;
      slot1 <= next1;
    end
  end

  assign fence_out = slot0.valid & slot0.fence;

  a_exc_no_unit: assert property (
    @(posedge clock) disable iff (!reset)
    !(slot0.exception && slot0.unit != unit_none) && !(slot1.exception && slot1.unit != unit_none)
  ) else $error("Exception slot carries a unit");

endmodule

`default_nettype wire

// File: logic/decode_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
  input  logic clock,
  input  logic reset,
  input  logic halt_set,
  input  logic halt_release,
  input  logic trap,
  input  logic mret,
  input  logic pred_miss,
  input  logic fence_out,
  output logic squash
);

  logic halt;

  always_ff @(posedge clock) begin
    if (!reset) begin
      halt <= 1'b0;
    end else if (halt_set) begin
      halt <= 1'b1;
    end else if (halt_release) begin
      halt <= 1'b0;
    end
  end

  // Fence squashes the entry behind it
  assign squash = trap | mret | pred_miss | halt | fence_out;

  a_halt_pulses: assert property (
    @(posedge clock) disable iff (!reset) !(halt_set && halt_release)
  ) else $error("halt_set and halt_release high together");

endmodule

`default_nettype wire

// File: logic/fp_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module fp_decoder import decode_pkg::*; (
  decode_result_if.decoder dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  funct5;
  logic [1:0]  fmt;
  logic        rm_ok;
  logic [31:0] imm_i;
  logic [31:0] imm_s;

  assign opcode = dec.instr[6:0];
  assign funct3 = dec.instr[14:12];
  assign funct5 = dec.instr[31:27];
  assign fmt    = dec.instr[26:25];
  assign rm_ok  = (funct3 != 3'b101) && (funct3 != 3'b110); // Reserved rounding modes
  assign imm_i  = {{20{dec.instr[31]}}, dec.instr[31:20]};
  assign imm_s  = {{20{dec.instr[31]}}, dec.instr[31:25], dec.instr[11:7]};

  always_comb begin
    dec.valid  = 1'b0;
    dec.unit   = unit_none;
    dec.alu_op = alu_add;
    dec.fp_op  = fp_none;
    dec.imm    = 32'd0;
    dec.wren   = 1'b0;
    dec.rden1  = 1'b0;
    dec.rden2  = 1'b0;
    dec.fwren  = 1'b0;
    dec.frden1 = 1'b0;
    dec.frden2 = 1'b0;
    dec.fence  = 1'b0;
    case (opcode)
      opc_flw: begin
        if (funct3 == 3'b010) begin
          dec.valid = 1'b1;
          dec.unit  = unit_fp_load;
          dec.imm   = imm_i;
          dec.rden1 = 1'b1; // Base address
          dec.fwren = 1'b1;
        end
      end
      opc_fsw: begin
        if (funct3 == 3'b010) begin
          dec.valid  = 1'b1;
          dec.unit   = unit_fp_store;
          dec.imm    = imm_s;
          dec.rden1  = 1'b1;
          dec.frden2 = 1'b1; // Store data
        end
      end
      opc_opfp: begin
        if (fmt == 2'b00) begin
          case (funct5)
            5'b00000: dec.fp_op = fp_add;
            5'b00001: dec.fp_op = fp_sub;
            5'b00010: dec.fp_op = fp_mul;
            5'b00011: dec.fp_op = fp_div;
            5'b00101: dec.fp_op = funct3[0] ? fp_max : fp_min;
            default:  dec.fp_op = fp_none;
          endcase
          if (funct5 == 5'b00101) begin
            dec.valid = (funct3[2:1] == 2'b00);
          end else begin
            dec.valid = (dec.fp_op != fp_none) && rm_ok;
          end
          if (dec.valid) begin
            dec.unit   = unit_fpu;
            dec.fwren  = 1'b1;
            dec.frden1 = 1'b1;
            dec.frden2 = 1'b1;
          end else begin
            dec.fp_op  = fp_none;
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/int_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module int_decoder import decode_pkg::*; (
  decode_result_if.decoder dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        f7_zero;
  logic        f7_alt;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode  = dec.instr[6:0];
  assign funct3  = dec.instr[14:12];
  assign funct7  = dec.instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000); // sub and sra

  assign imm_i = {{20{dec.instr[31]}}, dec.instr[31:20]};
  assign imm_s = {{20{dec.instr[31]}}, dec.instr[31:25], dec.instr[11:7]};
  assign imm_b = {{19{dec.instr[31]}}, dec.instr[31], dec.instr[7], dec.instr[30:25],
                  dec.instr[11:8], 1'b0};
  assign imm_u = {dec.instr[31:12], 12'b0};
  assign imm_j = {{11{dec.instr[31]}}, dec.instr[31], dec.instr[19:12], dec.instr[20],
                  dec.instr[30:21], 1'b0};

  always_comb begin
    dec.valid  = 1'b0;
    dec.unit   = unit_none;
    dec.alu_op = alu_add;
    dec.fp_op  = fp_none; // FP side belongs to fp_decoder
    dec.imm    = 32'd0;
    dec.wren   = 1'b0;
    dec.rden1  = 1'b0;
    dec.rden2  = 1'b0;
    dec.fwren  = 1'b0;
    dec.frden1 = 1'b0;
    dec.frden2 = 1'b0;
    dec.fence  = 1'b0;
    case (opcode)
      opc_lui, opc_auipc: begin
        dec.valid  = 1'b1;
        dec.unit   = unit_alu;
        dec.alu_op = (opcode == opc_lui) ? alu_lui : alu_auipc;
        dec.imm    = imm_u;
        dec.wren   = 1'b1;
      end
      opc_jal: begin
        dec.valid = 1'b1;
        dec.unit  = unit_jump;
        dec.imm   = imm_j;
        dec.wren  = 1'b1;
      end
      opc_jalr: begin
        dec.valid = (funct3 == 3'b000);
        dec.unit  = unit_jump;
        dec.imm   = imm_i;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
      end
      opc_branch: begin
        dec.valid = (funct3[2:1] != 2'b01);
        dec.unit  = unit_branch;
        dec.imm   = imm_b;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = alu_beq;
          3'b001:  dec.alu_op = alu_bne;
          3'b100:  dec.alu_op = alu_blt;
          3'b101:  dec.alu_op = alu_bge;
          3'b110:  dec.alu_op = alu_bltu;
          default: dec.alu_op = alu_bgeu;
        endcase
      end
      opc_load: begin
        dec.valid = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        dec.unit  = unit_load;
        dec.imm   = imm_i;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
      end
      opc_store: begin
        dec.valid = (funct3[2] == 1'b0) && (funct3 != 3'b011); // sb, sh, sw
        dec.unit  = unit_store;
        dec.imm   = imm_s;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
      end
      opc_imm, opc_op: begin
        dec.unit  = unit_alu;
        dec.imm   = (opcode == opc_imm) ? imm_i : 32'd0;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = (opcode == opc_op);
        dec.valid = (opcode == opc_imm) || f7_zero;
        case (funct3)
          3'b000: begin
            dec.alu_op = (opcode == opc_op && f7_alt) ? alu_sub : alu_add;
            dec.valid  = (opcode == opc_imm) || f7_zero || f7_alt;
          end
          3'b001: begin
            dec.alu_op = alu_sll;
            dec.valid  = f7_zero;
          end
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b101: begin
            dec.alu_op = f7_alt ? alu_sra : alu_srl;
            dec.valid  = f7_zero || f7_alt;
          end
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
        endcase
      end
      opc_fence: begin
        dec.valid = (funct3 == 3'b000);
        dec.unit  = unit_system;
        dec.fence = 1'b1;
      end
      opc_system: begin
        dec.valid = (dec.instr == 32'h0000_0073) || (dec.instr == 32'h0010_0073)
                    || (dec.instr == 32'h3020_0073); // ecall, ebreak, mret
        dec.unit  = unit_system;
      end
      default: begin
      end
    endcase
    if (!dec.valid) begin
      dec.unit   = unit_none; // Illegal words carry no operation
      dec.alu_op = alu_add;
      dec.imm    = 32'd0;
      dec.wren   = 1'b0;
      dec.rden1  = 1'b0;
      dec.rden2  = 1'b0;
      dec.fence  = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/decode_result_if.sv
`timescale 1ns/1ns
`default_nettype none

interface decode_result_if import decode_pkg::*; ();

  logic [31:0] instr;
  logic        valid;
  unit_t       unit;
  alu_op_t     alu_op;
  fp_op_t      fp_op;
  logic [31:0] imm;
  logic        wren;
  logic        rden1;
  logic        rden2;
  logic        fwren;
  logic        frden1;
  logic        frden2;
  logic        fence;

  modport decoder (
    input  instr,
    output valid, unit, alu_op, fp_op, imm,
    output wren, rden1, rden2, fwren, frden1, frden2, fence
  );

  modport stage (
    output instr,
    input  valid, unit, alu_op, fp_op, imm,
    input  wren, rden1, rden2, fwren, frden1, frden2, fence
  );

endinterface

`default_nettype wire

// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam logic [31:0] pc_none = 32'hFFFF_FFFF; // PC of an unfetched slot

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_fence  = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;
  localparam logic [6:0] opc_flw    = 7'b0000111;
  localparam logic [6:0] opc_fsw    = 7'b0100111;
  localparam logic [6:0] opc_opfp   = 7'b1010011;

  typedef enum logic [3:0] {
    unit_none     = 4'd0,
    unit_alu      = 4'd1,
    unit_branch   = 4'd2,
    unit_jump     = 4'd3,
    unit_load     = 4'd4,
    unit_store    = 4'd5,
    unit_system   = 4'd6,
    unit_fpu      = 4'd7,
    unit_fp_load  = 4'd8,
    unit_fp_store = 4'd9
  } unit_t;

  typedef enum logic [4:0] {
    alu_add   = 5'd0,
    alu_sub   = 5'd1,
    alu_sll   = 5'd2,
    alu_slt   = 5'd3,
    alu_sltu  = 5'd4,
    alu_xor   = 5'd5,
    alu_srl   = 5'd6,
    alu_sra   = 5'd7,
    alu_or    = 5'd8,
    alu_and   = 5'd9,
    alu_lui   = 5'd10,
    alu_auipc = 5'd11,
    alu_beq   = 5'd12, // Branch compares
    alu_bne   = 5'd13,
    alu_blt   = 5'd14,
    alu_bge   = 5'd15,
    alu_bltu  = 5'd16,
    alu_bgeu  = 5'd17
  } alu_op_t;

  typedef enum logic [2:0] {
    fp_none = 3'd0,
    fp_add  = 3'd1,
    fp_sub  = 3'd2,
    fp_mul  = 3'd3,
    fp_div  = 3'd4,
    fp_min  = 3'd5,
    fp_max  = 3'd6
  } fp_op_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] instr;
    logic [4:0]  waddr;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] imm;
    unit_t       unit;
    alu_op_t     alu_op;
    fp_op_t      fp_op;
    logic        wren;
    logic        rden1;
    logic        rden2;
    logic        fwren;
    logic        frden1;
    logic        frden2;
    logic        fence;
    logic        valid;
    logic        exception;
    logic        pred_taken;
    logic [31:0] pred_addr;
  } slot_t;

  localparam slot_t empty_slot = '{
    pc:         pc_none,
    npc:        32'd0,
    instr:      32'd0,
    waddr:      5'd0,
    raddr1:     5'd0,
    raddr2:     5'd0,
    imm:        32'd0,
    unit:       unit_none,
    alu_op:     alu_add,
    fp_op:      fp_none,
    wren:       1'b0,
    rden1:      1'b0,
    rden2:      1'b0,
    fwren:      1'b0,
    frden1:     1'b0,
    frden2:     1'b0,
    fence:      1'b0,
    valid:      1'b0,
    exception:  1'b0,
    pred_taken: 1'b0,
    pred_addr:  32'd0
  };

endpackage

`default_nettype wire
